// File: Makefile
# Verilator build and run of the convolution testbench

VERILATOR ?= verilator
TOP       ?= tb_conv2d_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  := Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sources.f
+incdir+include
src/conv2d_pkg.sv
src/conv2d_ctrl.sv
src/matrix_loader.sv
src/conv_engine.sv
src/matrix_storer.sv
src/conv2d_top.sv
tests/tb_conv2d_top.sv

// File: src/conv2d_ctrl.sv
`timescale 1ns/1ps

module conv2d_ctrl (
  input  logic                   clk,
  input  logic                   rstnn,
  input  logic                   i_inst_valid,
  input  conv2d_pkg::conv_inst_t i_inst,
  input  logic                   i_img_done,
  input  logic                   i_ker_done,
  input  logic                   i_exec_done,
  input  logic                   i_store_done,
  output logic                   o_inst_ready,
  output conv2d_pkg::phase_t     o_phase,
  output conv2d_pkg::conv_dims_t o_dims
);
  import conv2d_pkg::*;

  phase_t phase_q;
  phase_t phase_d;
  logic   inst_take;

  assign inst_take    = (phase_q == PH_IDLE) && i_inst_valid;
  assign o_inst_ready = (phase_q == PH_IDLE);
  assign o_phase      = phase_q;

  ////////////////////////////////////////
  // Phase sequencing
  ////////////////////////////////////////

  always_comb
  begin
    phase_d = phase_q;
    case (phase_q)
      PH_IDLE:
        if (i_inst_valid)
          phase_d = PH_LOAD;
      // Both row streams must have delivered their last row
      PH_LOAD:
        if (i_img_done && i_ker_done)
          phase_d = PH_EXEC;
      PH_EXEC:
        if (i_exec_done)
          phase_d = PH_STORE;
      PH_STORE:
        if (i_store_done)
          phase_d = PH_IDLE;
      default:
        phase_d = PH_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
      phase_q <= PH_IDLE;
    else
      phase_q <= phase_d;
  end

  ////////////////////////////////////////
  // Instruction register
  ////////////////////////////////////////

  // Output size is image minus kernel plus one, so the m1 forms just subtract
  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
      o_dims <= '0;
    else if (inst_take)
    begin
      o_dims.img_rows_m1 <= i_inst.img_rows_m1;
      o_dims.img_cols_m1 <= i_inst.img_cols_m1;
      o_dims.ker_rows_m1 <= i_inst.ker_rows_m1;
      o_dims.ker_cols_m1 <= i_inst.ker_cols_m1;
      o_dims.out_rows_m1 <= i_inst.img_rows_m1 - i_inst.ker_rows_m1;
      o_dims.out_cols_m1 <= i_inst.img_cols_m1 - i_inst.ker_cols_m1;
    end
  end

endmodule

// File: src/conv2d_pkg.sv
package conv2d_pkg;

  ////////////////////////////////////////
  // Element and count types
  ////////////////////////////////////////

  // One image or kernel element
  typedef logic signed [7:0] scalar_t;

  // One output element, exact for a full 3x3 window of 8-bit products
  typedef logic signed [19:0] acc_t;

  // Rows or columns minus one
  typedef logic [3:0] dim_t;

  // Largest supported matrices
  localparam int MAX_IMG_DEFAULT = 8;
  localparam int MAX_KER_DEFAULT = 3;

  ////////////////////////////////////////
  // Instruction and derived dimensions
  ////////////////////////////////////////

  typedef struct packed {
    dim_t img_rows_m1;
    dim_t img_cols_m1;
    dim_t ker_rows_m1;
    dim_t ker_cols_m1;
  } conv_inst_t;

  // Instruction fields plus output size, valid stride 1 and no padding
  typedef struct packed {
    dim_t img_rows_m1;
    dim_t img_cols_m1;
    dim_t ker_rows_m1;
    dim_t ker_cols_m1;
    dim_t out_rows_m1;
    dim_t out_cols_m1;
  } conv_dims_t;

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_LOAD,
    PH_EXEC,
    PH_STORE
  } phase_t;

endpackage

// File: src/conv2d_top.sv
`timescale 1ns/1ps

module conv2d_top #(
  parameter int IMG_DIM = conv2d_pkg::MAX_IMG_DEFAULT,
  parameter int KER_DIM = conv2d_pkg::MAX_KER_DEFAULT
) (
  input  logic                                clk,
  input  logic                                rstnn,
  input  logic                                i_inst_valid,
  input  conv2d_pkg::conv_inst_t              i_inst,
  output logic                                o_inst_ready,
  input  logic                                i_img_valid,
  input  logic                                i_img_last,
  input  conv2d_pkg::scalar_t [IMG_DIM-1:0]   i_img_row,
  output logic                                o_img_ready,
  input  logic                                i_ker_valid,
  input  logic                                i_ker_last,
  input  conv2d_pkg::scalar_t [KER_DIM-1:0]   i_ker_row,
  output logic                                o_ker_ready,
  output logic                                o_out_valid,
  output logic                                o_out_last,
  output conv2d_pkg::acc_t [IMG_DIM-1:0]      o_out_row,
  input  logic                                i_out_ready
);
  import conv2d_pkg::*;

  phase_t                               phase;
  conv_dims_t                           dims;
  scalar_t [IMG_DIM-1:0][IMG_DIM-1:0]   img_mat;
  scalar_t [KER_DIM-1:0][KER_DIM-1:0]   ker_mat;
  logic                                 img_done;
  logic                                 ker_done;
  logic                                 exec_done;
  logic                                 store_done;
  logic                                 wr_en;
  dim_t                                 wr_row;
  dim_t                                 wr_col;
  acc_t                                 wr_data;

  ////////////////////////////////////////
  // Phase control
  ////////////////////////////////////////

  conv2d_ctrl u_ctrl (
    .clk          (clk),
    .rstnn        (rstnn),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_img_done   (img_done),
    .i_ker_done   (ker_done),
    .i_exec_done  (exec_done),
    .i_store_done (store_done),
    .o_inst_ready (o_inst_ready),
    .o_phase      (phase),
    .o_dims       (dims)
  );

  ////////////////////////////////////////
  // Input matrices
  ////////////////////////////////////////

  matrix_loader #(.DIM(IMG_DIM)) u_img_loader (
    .clk         (clk),
    .rstnn       (rstnn),
    .i_phase     (phase),
    .i_row_valid (i_img_valid),
    .i_row_last  (i_img_last),
    .i_row       (i_img_row),
    .o_row_ready (o_img_ready),
    .o_done      (img_done),
    .o_matrix    (img_mat)
  );

  matrix_loader #(.DIM(KER_DIM)) u_ker_loader (
    .clk         (clk),
    .rstnn       (rstnn),
    .i_phase     (phase),
    .i_row_valid (i_ker_valid),
    .i_row_last  (i_ker_last),
    .i_row       (i_ker_row),
    .o_row_ready (o_ker_ready),
    .o_done      (ker_done),
    .o_matrix    (ker_mat)
  );

  ////////////////////////////////////////
  // Compute and output
  ////////////////////////////////////////

  conv_engine #(
    .IMG_DIM (IMG_DIM),
    .KER_DIM (KER_DIM)
  ) u_engine (
    .clk         (clk),
    .rstnn       (rstnn),
    .i_phase     (phase),
    .i_dims      (dims),
    .i_img       (img_mat),
    .i_ker       (ker_mat),
    .o_wr_en     (wr_en),
    .o_wr_row    (wr_row),
    .o_wr_col    (wr_col),
    .o_wr_data   (wr_data),
    .o_exec_done (exec_done)
  );

  matrix_storer #(.IMG_DIM(IMG_DIM)) u_storer (
    .clk          (clk),
    .rstnn        (rstnn),
    .i_phase      (phase),
    .i_dims       (dims),
    .i_wr_en      (wr_en),
    .i_wr_row     (wr_row),
    .i_wr_col     (wr_col),
    .i_wr_data    (wr_data),
    .i_out_ready  (i_out_ready),
    .o_out_valid  (o_out_valid),
    .o_out_last   (o_out_last),
    .o_out_row    (o_out_row),
    .o_store_done (store_done)
  );

endmodule

// File: src/conv_engine.sv
`timescale 1ns/1ps

module conv_engine #(
  parameter int IMG_DIM = conv2d_pkg::MAX_IMG_DEFAULT,
  parameter int KER_DIM = conv2d_pkg::MAX_KER_DEFAULT
) (
  input  logic                                           clk,
  input  logic                                           rstnn,
  input  conv2d_pkg::phase_t                             i_phase,
  input  conv2d_pkg::conv_dims_t                         i_dims,
  input  conv2d_pkg::scalar_t [IMG_DIM-1:0][IMG_DIM-1:0] i_img,
  input  conv2d_pkg::scalar_t [KER_DIM-1:0][KER_DIM-1:0] i_ker,
  output logic                                           o_wr_en,
  output conv2d_pkg::dim_t                               o_wr_row,
  output conv2d_pkg::dim_t                               o_wr_col,
  output conv2d_pkg::acc_t                               o_wr_data,
  output logic                                           o_exec_done
);
  import conv2d_pkg::*;

  dim_t    out_r;
  dim_t    out_c;
  dim_t    ker_r;
  dim_t    ker_c;
  dim_t    img_r;
  dim_t    img_c;
  scalar_t img_val;
  scalar_t ker_val;
  acc_t    prod;
  acc_t    acc;
  acc_t    sum;
  logic    finished;
  logic    step;
  logic    last_kc;
  logic    last_kr;
  logic    last_oc;
  logic    last_or;
  logic    win_end;
  logic    all_end;

  // One product per cycle until the last window is through
  assign step = (i_phase == PH_EXEC) && !finished;

  ////////////////////////////////////////
  // Window addressing and product
  ////////////////////////////////////////

  assign img_r   = out_r + ker_r;
  assign img_c   = out_c + ker_c;
  assign img_val = i_img[img_r][img_c];
  assign ker_val = i_ker[ker_r][ker_c];
  // Both operands signed, extended to the accumulator width
  assign prod    = img_val * ker_val;
  assign sum     = acc + prod;

  assign last_kc = (ker_c == i_dims.ker_cols_m1);
  assign last_kr = (ker_r == i_dims.ker_rows_m1);
  assign last_oc = (out_c == i_dims.out_cols_m1);
  assign last_or = (out_r == i_dims.out_rows_m1);
  assign win_end = last_kc && last_kr;
  assign all_end = win_end && last_oc && last_or;

  ////////////////////////////////////////
  // Nested counters and accumulator
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      out_r    <= '0;
      out_c    <= '0;
      ker_r    <= '0;
      ker_c    <= '0;
      acc      <= '0;
      finished <= 1'b0;
    end
    else if (i_phase != PH_EXEC)
    begin
      out_r    <= '0;
      out_c    <= '0;
      ker_r    <= '0;
      ker_c    <= '0;
      acc      <= '0;
      finished <= 1'b0;
    end
    else if (step)
    begin
      // Restart the sum at each window boundary
      acc <= win_end ? '0 : sum;
      if (!last_kc)
        ker_c <= ker_c + 1'b1;
      else
      begin
        ker_c <= '0;
        if (!last_kr)
          ker_r <= ker_r + 1'b1;
        else
        begin
          ker_r <= '0;
          if (!last_oc)
            out_c <= out_c + 1'b1;
          else
          begin
            out_c <= '0;
            if (!last_or)
              out_r <= out_r + 1'b1;
            else
              finished <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Result write and done pulse
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      o_wr_en     <= 1'b0;
      o_exec_done <= 1'b0;
    end
    else
    begin
      o_wr_en     <= step && win_end;
      // Lands together with the final element write
      o_exec_done <= step && all_end;
    end
  end

  always_ff @(posedge clk)
  begin
    if (step && win_end)
    begin
      o_wr_row  <= out_r;
      o_wr_col  <= out_c;
      o_wr_data <= sum;
    end
  end

endmodule

// File: src/matrix_loader.sv
`timescale 1ns/1ps

module matrix_loader #(
  parameter int DIM = conv2d_pkg::MAX_IMG_DEFAULT
) (
  input  logic                                  clk,
  input  logic                                  rstnn,
  input  conv2d_pkg::phase_t                    i_phase,
  input  logic                                  i_row_valid,
  input  logic                                  i_row_last,
  input  conv2d_pkg::scalar_t [DIM-1:0]         i_row,
  output logic                                  o_row_ready,
  output logic                                  o_done,
  output conv2d_pkg::scalar_t [DIM-1:0][DIM-1:0] o_matrix
);
  import conv2d_pkg::*;

  dim_t row_cnt;
  logic row_take;

  // Ready only while loading and until the last row has gone in
  assign o_row_ready = (i_phase == PH_LOAD) && !o_done;
  assign row_take    = o_row_ready && i_row_valid;

  ////////////////////////////////////////
  // Row counter and done flag
  ////////////////////////////////////////

  // Held clear outside the load phase, so every load starts at row 0
  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
    begin
      row_cnt <= '0;
      o_done  <= 1'b0;
    end
    else if (i_phase != PH_LOAD)
    begin
      row_cnt <= '0;
      o_done  <= 1'b0;
    end
    else if (row_take)
    begin
      row_cnt <= row_cnt + 1'b1;
      o_done  <= i_row_last;
    end
  end

  ////////////////////////////////////////
  // Matrix register
  ////////////////////////////////////////

  // Whole row in one write, unused columns carried along
  always_ff @(posedge clk)
  begin
    if (row_take)
      o_matrix[row_cnt] <= i_row;
  end

endmodule

// File: src/matrix_storer.sv
`timescale 1ns/1ps

module matrix_storer #(
  parameter int IMG_DIM = conv2d_pkg::MAX_IMG_DEFAULT
) (
  input  logic                            clk,
  input  logic                            rstnn,
  input  conv2d_pkg::phase_t              i_phase,
  input  conv2d_pkg::conv_dims_t          i_dims,
  input  logic                            i_wr_en,
  input  conv2d_pkg::dim_t                i_wr_row,
  input  conv2d_pkg::dim_t                i_wr_col,
  input  conv2d_pkg::acc_t                i_wr_data,
  input  logic                            i_out_ready,
  output logic                            o_out_valid,
  output logic                            o_out_last,
  output conv2d_pkg::acc_t [IMG_DIM-1:0]  o_out_row,
  output logic                            o_store_done
);
  import conv2d_pkg::*;

  acc_t [IMG_DIM-1:0][IMG_DIM-1:0] out_mat;
  phase_t                          phase_q;
  dim_t                            rd_row;
  logic                            exec_start;
  logic                            row_take;

  // First cycle of execute
  assign exec_start = (i_phase == PH_EXEC) && (phase_q != PH_EXEC);

  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
      phase_q <= PH_IDLE;
    else
      phase_q <= i_phase;
  end

  ////////////////////////////////////////
  // Output matrix
  ////////////////////////////////////////

  // Zeroed before the first engine write, so inactive columns read back as 0
  always_ff @(posedge clk)
  begin
    if (exec_start)
      out_mat <= '0;
    else if (i_wr_en)
      out_mat[i_wr_row][i_wr_col] <= i_wr_data;
  end

  ////////////////////////////////////////
  // Row stream out
  ////////////////////////////////////////

  assign o_out_valid  = (i_phase == PH_STORE);
  assign row_take     = o_out_valid && i_out_ready;
  assign o_out_last   = o_out_valid && (rd_row == i_dims.out_rows_m1);
  assign o_out_row    = out_mat[rd_row];
  assign o_store_done = row_take && o_out_last;

  // Row index only moves on an accepted row, which holds the output under stall
  always_ff @(posedge clk or negedge rstnn)
  begin
    if (!rstnn)
      rd_row <= '0;
    else if (i_phase != PH_STORE)
      rd_row <= '0;
    else if (row_take)
      rd_row <= rd_row + 1'b1;
  end

endmodule

// File: include/conv2d_tb_util.svh
`ifndef CONV2D_TB_UTIL_SVH
`define CONV2D_TB_UTIL_SVH

////////////////////////////////////////
// Random numbers
////////////////////////////////////////

localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

// Galois form, shifting right
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0])
    n = n ^ LFSR_TAPS;
  return n;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    stim_lfsr = lfsr_next(stim_lfsr);
    v = {v[30:0], stim_lfsr[0]};
  end
  return v;
endfunction

////////////////////////////////////////
// Reference model
////////////////////////////////////////

// Exact sum over one kernel window, r and c give the output position
function automatic acc_t ref_conv2d(input int r, input int c, input int kr, input int kc);
  int sum;
  int ir;
  int ic;
  sum = 0;
  for (int i = 0; i < kr; i++)
  begin
    for (int j = 0; j < kc; j++)
    begin
      ir = r + i;
      ic = c + j;
      sum += int'(img_m[ir][ic]) * int'(ker_m[i][j]);
    end
  end
  return acc_t'(sum);
endfunction

////////////////////////////////////////
// Waits, each returning at a negedge
////////////////////////////////////////

task automatic wait_inst_ready();
  int n;
  n = 0;
  @(negedge clk);
  while (!o_inst_ready)
  begin
    n++;
    if (n > WAIT_LIMIT)
      run_error("Timed out waiting for o_inst_ready");
    @(negedge clk);
  end
endtask

task automatic wait_img_ready();
  int n;
  n = 0;
  @(negedge clk);
  while (!o_img_ready)
  begin
    n++;
    if (n > WAIT_LIMIT)
      run_error("Timed out waiting for o_img_ready");
    @(negedge clk);
  end
endtask

task automatic wait_ker_ready();
  int n;
  n = 0;
  @(negedge clk);
  while (!o_ker_ready)
  begin
    n++;
    if (n > WAIT_LIMIT)
      run_error("Timed out waiting for o_ker_ready");
    @(negedge clk);
  end
endtask

// Until every accepted instruction has streamed out its last row
task automatic wait_jobs_done();
  int n;
  n = 0;
  while (jobs_done != jobs_issued)
  begin
    n++;
    if (n > 4 * WAIT_LIMIT)
      run_error("Timed out waiting for the last output rows");
    @(negedge clk);
  end
endtask

`endif

// File: tests/tb_conv2d_top.sv
`timescale 1ns/1ps

module tb_conv2d_top;
  import conv2d_pkg::*;

  localparam int          IMG_DIM    = MAX_IMG_DEFAULT;
  localparam int          KER_DIM    = MAX_KER_DEFAULT;
  localparam int          WAIT_LIMIT = 2000;
  localparam logic [31:0] LFSR_SEED  = 32'he70b_c4b5;

  logic                       clk;
  logic                       rstnn;
  logic                       i_inst_valid;
  conv_inst_t                 i_inst;
  logic                       o_inst_ready;
  logic                       i_img_valid;
  logic                       i_img_last;
  scalar_t [IMG_DIM-1:0]      i_img_row;
  logic                       o_img_ready;
  logic                       i_ker_valid;
  logic                       i_ker_last;
  scalar_t [KER_DIM-1:0]      i_ker_row;
  logic                       o_ker_ready;
  logic                       o_out_valid;
  logic                       o_out_last;
  acc_t [IMG_DIM-1:0]         o_out_row;
  logic                       i_out_ready;

  // Matrices of the instruction being issued
  scalar_t            img_m [IMG_DIM][IMG_DIM];
  scalar_t            ker_m [KER_DIM][KER_DIM];

  // Expected rows in order, and the row count of each instruction
  acc_t [IMG_DIM-1:0] exp_rows [$];
  int                 job_rows [$];
  int                 jobs_issued;
  int                 jobs_done;
  logic               out_gaps;
  logic [31:0]        stim_lfsr;
  logic [31:0]        sink_lfsr;

  conv2d_top #(
    .IMG_DIM (IMG_DIM),
    .KER_DIM (KER_DIM)
  ) dut_i (
    .clk          (clk),
    .rstnn        (rstnn),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_inst_ready (o_inst_ready),
    .i_img_valid  (i_img_valid),
    .i_img_last   (i_img_last),
    .i_img_row    (i_img_row),
    .o_img_ready  (o_img_ready),
    .i_ker_valid  (i_ker_valid),
    .i_ker_last   (i_ker_last),
    .i_ker_row    (i_ker_row),
    .o_ker_ready  (o_ker_ready),
    .o_out_valid  (o_out_valid),
    .o_out_last   (o_out_last),
    .o_out_row    (o_out_row),
    .i_out_ready  (i_out_ready)
  );

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic end_in_failure();
    $display("Result: FAILED");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic value_error(input string msg);
    $display("[ERROR] %0t ns %s", $time, msg);
    end_in_failure();
  endtask

  task automatic run_error(input string msg);
    $display("%s", msg);
    end_in_failure();
  endtask

  `include "conv2d_tb_util.svh"

  task automatic check_row(input acc_t [IMG_DIM-1:0] got, input acc_t [IMG_DIM-1:0] want);
    for (int c = 0; c < IMG_DIM; c++)
    begin
      if (got[c] !== want[c])
        value_error($sformatf("o_out_row column %0d is %0d, expected %0d",
                              c, got[c], want[c]));
    end
  endtask

  task automatic check_last(input logic got, input logic want);
    if (got !== want)
      value_error($sformatf("o_out_last is %b, expected %b", got, want));
  endtask

  task automatic check_ready(input string name, input logic got, input logic want);
    if (got !== want)
      value_error($sformatf("%s is %b, expected %b", name, got, want));
  endtask

  ////////////////////////////////////////
  // Row streams in
  ////////////////////////////////////////

  task automatic send_ker_rows(input int nrows, input logic gaps);
    int r;
    r = 0;
    while (r < nrows)
    begin
      if (gaps && rand_bits(2) == 0)
        i_ker_valid = 1'b0;
      else
      begin
        i_ker_valid = 1'b1;
        i_ker_last  = (r == nrows - 1);
        for (int c = 0; c < KER_DIM; c++)
          i_ker_row[c] = ker_m[r][c];
        wait_ker_ready();
        r++;
      end
      @(posedge clk);
      #1;
    end
    i_ker_valid = 1'b0;
    i_ker_last  = 1'b0;
  endtask

  task automatic send_img_rows(input int nrows, input logic gaps);
    int r;
    r = 0;
    while (r < nrows)
    begin
      if (gaps && rand_bits(2) == 0)
        i_img_valid = 1'b0;
      else
      begin
        i_img_valid = 1'b1;
        i_img_last  = (r == nrows - 1);
        // Columns past the active width carry junk on purpose
        for (int c = 0; c < IMG_DIM; c++)
          i_img_row[c] = img_m[r][c];
        wait_img_ready();
        r++;
      end
      @(posedge clk);
      #1;
    end
    i_img_valid = 1'b0;
    i_img_last  = 1'b0;
  endtask

  // One instruction with sizes as real row and column counts
  task automatic run_job(input int ir, input int ic, input int kr, input int kc,
                         input logic gaps);
    acc_t [IMG_DIM-1:0] row;
    for (int r = 0; r < IMG_DIM; r++)
    begin
      for (int c = 0; c < IMG_DIM; c++)
        img_m[r][c] = scalar_t'(rand_bits(8));
    end
    for (int r = 0; r < KER_DIM; r++)
    begin
      for (int c = 0; c < KER_DIM; c++)
        ker_m[r][c] = scalar_t'(rand_bits(8));
    end
    for (int r = 0; r <= ir - kr; r++)
    begin
      row = '0;
      for (int c = 0; c <= ic - kc; c++)
        row[c] = ref_conv2d(r, c, kr, kc);
      exp_rows.push_back(row);
    end
    job_rows.push_back(ir - kr + 1);
    out_gaps           = gaps;
    i_inst.img_rows_m1 = dim_t'(ir - 1);
    i_inst.img_cols_m1 = dim_t'(ic - 1);
    i_inst.ker_rows_m1 = dim_t'(kr - 1);
    i_inst.ker_cols_m1 = dim_t'(kc - 1);
    i_inst_valid       = 1'b1;
    wait_inst_ready();
    @(posedge clk);
    #1;
    i_inst_valid = 1'b0;
    jobs_issued++;
    send_ker_rows(kr, gaps);
    send_img_rows(ir, gaps);
  endtask

  ////////////////////////////////////////
  // Clock, reset and stimulus
  ////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  initial
  begin
    rstnn        = 1'b0;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    i_img_valid  = 1'b0;
    i_img_last   = 1'b0;
    i_img_row    = '0;
    i_ker_valid  = 1'b0;
    i_ker_last   = 1'b0;
    i_ker_row    = '0;
    jobs_issued  = 0;
    out_gaps     = 1'b0;
    stim_lfsr    = LFSR_SEED;
    repeat (8) @(posedge clk);
    #1;
    rstnn = 1'b1;

    @(negedge clk);
    check_ready("o_inst_ready", o_inst_ready, 1'b1);
    check_ready("o_img_ready", o_img_ready, 1'b0);
    check_ready("o_ker_ready", o_ker_ready, 1'b0);
    check_ready("o_out_valid", o_out_valid, 1'b0);
    check_last(o_out_last, 1'b0);
    @(posedge clk);
    #1;

    run_job(8, 8, 3, 3, 1'b0);
    run_job(5, 7, 2, 3, 1'b0);
    // Back to back with stalls on both sides
    run_job(6, 8, 3, 2, 1'b1);
    run_job(8, 8, 3, 3, 1'b1);
    run_job(4, 4, 1, 1, 1'b1);
    wait_jobs_done();

    // Back in idle once the last row has gone out
    @(negedge clk);
    check_ready("o_inst_ready after the last job", o_inst_ready, 1'b1);
    check_ready("o_img_ready after the last job", o_img_ready, 1'b0);
    check_ready("o_ker_ready after the last job", o_ker_ready, 1'b0);
    check_ready("o_out_valid after the last job", o_out_valid, 1'b0);
    check_last(o_out_last, 1'b0);

    $display("Result: PASSED");
    $finish;
  end

  // Output back-pressure is random only in the gap tests
  initial
  begin
    i_out_ready = 1'b0;
    sink_lfsr   = LFSR_SEED;
    forever
    begin
      @(posedge clk);
      #1;
      sink_lfsr   = lfsr_next(sink_lfsr);
      i_out_ready = sink_lfsr[0] || !out_gaps;
    end
  end

  ////////////////////////////////////////
  // Output rows sampled mid-cycle
  ////////////////////////////////////////

  initial
  begin : compare_rows
    acc_t [IMG_DIM-1:0] held_row;
    logic               held_last;
    logic               holding;
    int                 row_idx;
    int                 quiet;
    jobs_done = 0;
    holding   = 1'b0;
    row_idx   = 0;
    quiet     = 0;
    forever
    begin
      @(negedge clk);
      // A stalled row must not move
      if (holding)
      begin
        check_ready("o_out_valid under stall", o_out_valid, 1'b1);
        check_row(o_out_row, held_row);
        check_last(o_out_last, held_last);
      end
      holding   = o_out_valid && !i_out_ready;
      held_row  = o_out_row;
      held_last = o_out_last;

      if (jobs_issued != jobs_done)
      begin
        check_ready("o_inst_ready while busy", o_inst_ready, 1'b0);
        quiet++;
        if (quiet > WAIT_LIMIT)
          run_error("Timed out waiting for an output row");
      end

      if (o_out_valid && i_out_ready)
      begin
        quiet = 0;
        if (exp_rows.size() == 0 || job_rows.size() == 0)
          run_error("Output row seen when none was expected");
        check_row(o_out_row, exp_rows.pop_front());
        check_last(o_out_last, row_idx == job_rows[0] - 1);
        row_idx++;
        if (row_idx == job_rows[0])
        begin
          void'(job_rows.pop_front());
          row_idx = 0;
          jobs_done++;
        end
      end
    end
  end

endmodule
